//--- list.f
src/ppc_decode_pkg.sv
src/decode_if.sv
src/ds_format_decoder.sv
src/d_format_decoder.sv
src/decode_merge.sv
src/ppc_decode_top.sv
sim/tb_ppc_decode.sv

//--- run.sh
#!/bin/sh
rm -f sim.log
verilator --binary --timing --assert --top-module tb_ppc_decode -f list.f > sim.log 2>&1 &&
	./obj_dir/Vtb_ppc_decode >> sim.log 2>&1 ||
	echo "*** TEST FAILED ***" >> sim.log
cat sim.log
if grep -qF "*** TEST FAILED ***" sim.log; then exit 1; fi
exit 0

//--- sim/tb_ppc_decode.sv
`timescale 1ns/1ps

module tb_ppc_decode import ppc_decode_pkg::*; ();

	typedef struct packed {
		logic             valid;
		logic             illegal;
		decode_op_e       op;
		logic [reg_w-1:0] rt;
		logic [reg_w-1:0] ra;
		logic             raz;
		logic [63:0]      imm;
		logic [63:0]      pc;
	} exp_t;

	logic                clock = 1'b0;
	logic                arst_n;
	logic                enable;
	logic [0:instr_w-1]  instr;
	logic [addr_w-1:0]   pc;
	logic                valid;
	logic                illegal;
	decode_op_e          op;
	logic [reg_w-1:0]    rt;
	logic [reg_w-1:0]    ra;
	logic                ra_or_zero;
	logic [addr_w-1:0]   imm;
	logic [addr_w-1:0]   pc_out;

	exp_t        exp_q[$];   // One entry per driven cycle, in issue order
	string       name_q[$];
	exp_t        cur_exp;
	string       cur_name;
	logic        check_en = 1'b0;
	logic [63:0] next_pc = 64'h0000_0000_0001_0000;
	int          issued = 0;
	int          cycle_count = 0;

	// D-format opcodes in the order addi, addis, ori, andi, lwz, stw
	logic [5:0] opc_list [6] = '{6'd14, 6'd15, 6'd24, 6'd28, 6'd32, 6'd36};

	ppc_decode_top i_dut (
		.clock_i      (clock),
		.arst_n_i     (arst_n),
		.enable_i     (enable),
		.instr_i      (instr),
		.pc_i         (pc),
		.valid_o      (valid),
		.illegal_o    (illegal),
		.op_o         (op),
		.rt_o         (rt),
		.ra_o         (ra),
		.ra_or_zero_o (ra_or_zero),
		.imm_o        (imm),
		.pc_o         (pc_out)
	);

	always #2 clock = ~clock;

	always @(posedge clock) cycle_count <= cycle_count + 1;

	function automatic logic [0:31] ds_word(input logic [5:0] opc, input logic [4:0] rt_f,
		input logic [4:0] ra_f, input logic [13:0] ds, input logic [1:0] xo);
		return {opc, rt_f, ra_f, ds, xo};
	endfunction

	function automatic logic [0:31] d_word(input logic [5:0] opc, input logic [4:0] rt_f,
		input logic [4:0] ra_f, input logic [15:0] si);
		return {opc, rt_f, ra_f, si};
	endfunction

	// Reference model built from the ISA field layout
	function automatic exp_t expect_word(input logic en, input logic [0:31] w,
		input logic [63:0] pc_w);
		exp_t       e;
		logic [5:0] opc;
		logic [1:0] xo;
		e = '0;
		e.op = op_none;
		opc = w[0:5];
		xo = w[30:31];
		if (!en)
			return e; // Disabled words leave the outputs idle
		e.pc = pc_w;
		e.rt = w[6:10];
		e.ra = w[11:15];
		e.raz = 1'b1;
		e.valid = 1'b1;
		case (opc)
			6'd58, 6'd62: begin
				e.imm = {{48{w[16]}}, w[16:29], 2'b00};
				case (xo)
					2'd0: e.op = (opc == 6'd58) ? op_ld : op_std;
					2'd1: begin
						e.op = (opc == 6'd58) ? op_ldu : op_stdu;
						e.raz = 1'b0;
					end
					2'd2: e.op = (opc == 6'd58) ? op_lwa : op_stq;
					default: begin
						e.valid = 1'b0;
						e.illegal = 1'b1;
					end
				endcase
			end
			6'd14: begin
				e.op = op_addi;
				e.imm = {{48{w[16]}}, w[16:31]};
			end
			6'd15: begin
				e.op = op_addis;
				e.imm = {{32{w[16]}}, w[16:31], 16'h0000};
			end
			6'd24, 6'd28: begin
				e.op = (opc == 6'd24) ? op_ori : op_andi;
				e.imm = {48'h0, w[16:31]};
				e.raz = 1'b0;
			end
			6'd32, 6'd36: begin
				e.op = (opc == 6'd32) ? op_lwz : op_stw;
				e.imm = {{48{w[16]}}, w[16:31]};
			end
			default: begin
				e.valid = 1'b0;
				e.illegal = 1'b1;
			end
		endcase
		return e;
	endfunction

	task automatic drive_word(input logic en, input logic [0:31] word, input string name);
		@(posedge clock);
		enable <= en;
		instr <= word;
		pc <= next_pc;
		exp_q.push_back(expect_word(en, word, next_pc));
		name_q.push_back(name);
		next_pc = next_pc + 64'd4;
		issued++;
	endtask

	task automatic report_mismatch(input string field, input logic [63:0] expv,
		input logic [63:0] actv);
		$display("MISMATCH test=%s field=%s expected=0x%0h actual=0x%0h",
			cur_name, field, expv, actv);
		$display("*** TEST FAILED ***");
		$fatal(1, "Stopping at the first error");
	endtask

	// Output after edge M belongs to the word driven at edge M-2
	always @(negedge clock) begin
		if (exp_q.size() > 0) begin
			cur_exp = exp_q.pop_front();
			cur_name = name_q.pop_front();
			check_en = 1'b1;
		end else begin
			check_en = 1'b0;
		end
	end

	assert property (@(posedge clock) disable iff (!check_en)
		valid == cur_exp.valid && illegal == cur_exp.illegal)
		else report_mismatch("valid_illegal", 64'({cur_exp.valid, cur_exp.illegal}),
			64'({$sampled(valid), $sampled(illegal)}));

	assert property (@(posedge clock) disable iff (!check_en) op == cur_exp.op)
		else report_mismatch("op", 64'(cur_exp.op), 64'($sampled(op)));

	assert property (@(posedge clock) disable iff (!check_en)
		cur_exp.valid |-> (rt == cur_exp.rt && ra == cur_exp.ra && ra_or_zero == cur_exp.raz))
		else report_mismatch("rt_ra_raz", 64'({cur_exp.rt, cur_exp.ra, cur_exp.raz}),
			64'({$sampled(rt), $sampled(ra), $sampled(ra_or_zero)}));

	assert property (@(posedge clock) disable iff (!check_en) cur_exp.valid |-> imm == cur_exp.imm)
		else report_mismatch("imm", cur_exp.imm, $sampled(imm));

	assert property (@(posedge clock) disable iff (!check_en)
		(cur_exp.valid || cur_exp.illegal) |-> pc_out == cur_exp.pc)
		else report_mismatch("pc", cur_exp.pc, $sampled(pc_out));

	initial begin
		while (cycle_count <= (issued + 50) * 2)
			@(posedge clock);
		$display("Timeout: run did not finish, %0d words issued", issued);
		$display("*** TEST FAILED ***");
		$fatal(1, "Run exceeded its cycle limit");
	end

	initial begin
		logic [31:0] r;
		logic [5:0]  opc;
		logic        en;
		int          sel;
		void'($urandom(32'hf0640fcb));
		arst_n = 1'b0;
		enable = 1'b0;
		instr = '0;
		pc = '0;
		repeat (3) @(posedge clock);
		arst_n <= 1'b1;
		repeat (3) begin // Idle results right after reset
			exp_q.push_back(expect_word(1'b0, 32'h0, 64'h0));
			name_q.push_back("reset");
		end
		repeat (3) drive_word(1'b0, 32'h0, "idle");
		for (int x = 0; x < 3; x++) begin
			drive_word(1'b1, ds_word(6'd58, 5'd3, 5'd1, 14'h2001, 2'(x)), "ds_load_neg");
			drive_word(1'b1, ds_word(6'd58, 5'd31, 5'd0, 14'h0abc, 2'(x)), "ds_load_pos");
			drive_word(1'b1, ds_word(6'd62, 5'd7, 5'd9, 14'h3ffe, 2'(x)), "ds_store_neg");
			drive_word(1'b1, ds_word(6'd62, 5'd12, 5'd30, 14'h1555, 2'(x)), "ds_store_pos");
		end
		foreach (opc_list[k]) begin
			drive_word(1'b1, d_word(opc_list[k], 5'd4, 5'd5, 16'h8123), "d_top_set");
			drive_word(1'b1, d_word(opc_list[k], 5'd17, 5'd0, 16'h1234), "d_top_clear");
		end
		drive_word(1'b1, d_word(6'd5, 5'd1, 5'd2, 16'hbeef), "illegal_opcode");
		drive_word(1'b1, ds_word(6'd58, 5'd1, 5'd2, 14'h0010, 2'd3), "illegal_ds_load_xo3");
		drive_word(1'b1, ds_word(6'd62, 5'd1, 5'd2, 14'h0010, 2'd3), "illegal_ds_store_xo3");
		drive_word(1'b0, ds_word(6'd58, 5'd1, 5'd2, 14'h0010, 2'd0), "disabled_ld");
		drive_word(1'b0, d_word(6'd14, 5'd1, 5'd2, 16'h0001), "disabled_addi");
		drive_word(1'b0, d_word(6'd9, 5'd1, 5'd2, 16'h0001), "disabled_unknown");
		for (int i = 0; i < 400; i++) begin
			r = $urandom;
			sel = int'($urandom % 10);
			case (sel)
				0: opc = 6'd14;
				1: opc = 6'd15;
				2: opc = 6'd24;
				3: opc = 6'd28;
				4: opc = 6'd32;
				5: opc = 6'd36;
				6: opc = 6'd58;
				7: opc = 6'd62;
				default: opc = r[31:26];
			endcase
			en = ($urandom % 4) != 0;
			drive_word(en, {opc, r[25:0]}, "random");
		end
		repeat (3) drive_word(1'b0, 32'h0, "drain");
		while (exp_q.size() != 0)
			@(posedge clock);
		repeat (2) @(posedge clock);
		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

//--- src/ppc_decode_top.sv
`timescale 1ns/1ps

// Load/store and immediate decode slice, two cycles from word to result
module ppc_decode_top import ppc_decode_pkg::*; (
	input  logic                clock_i,
	input  logic                arst_n_i,
	input  logic                enable_i,
	input  logic [0:instr_w-1]  instr_i, // Big-endian bit numbering
	input  logic [addr_w-1:0]   pc_i,
	output logic                valid_o,
	output logic                illegal_o,
	output decode_op_e          op_o,
	output logic [reg_w-1:0]    rt_o,
	output logic [reg_w-1:0]    ra_o,
	output logic                ra_or_zero_o,
	output logic [addr_w-1:0]   imm_o,
	output logic [addr_w-1:0]   pc_o
);

	decode_if ds_bus ();
	decode_if d_bus ();

	ds_format_decoder i_ds_dec (
		.clock_i  (clock_i),
		.arst_n_i (arst_n_i),
		.enable_i (enable_i),
		.instr_i  (instr_i),
		.bus_o    (ds_bus)
	);

	d_format_decoder i_d_dec (
		.clock_i  (clock_i),
		.arst_n_i (arst_n_i),
		.enable_i (enable_i),
		.instr_i  (instr_i),
		.bus_o    (d_bus)
	);

	decode_merge i_merge (
		.clock_i      (clock_i),
		.arst_n_i     (arst_n_i),
		.enable_i     (enable_i),
		.pc_i         (pc_i),
		.ds_i         (ds_bus),
		.d_i          (d_bus),
		.valid_o      (valid_o),
		.illegal_o    (illegal_o),
		.op_o         (op_o),
		.rt_o         (rt_o),
		.ra_o         (ra_o),
		.ra_or_zero_o (ra_or_zero_o),
		.imm_o        (imm_o),
		.pc_o         (pc_o)
	);

endmodule

//--- src/decode_merge.sv
`timescale 1ns/1ps

// Picks the claiming decoder, widens the immediate and flags unclaimed words
module decode_merge import ppc_decode_pkg::*; (
	input  logic                clock_i,
	input  logic                arst_n_i,
	input  logic                enable_i,
	input  logic [addr_w-1:0]   pc_i,
	decode_if.sink              ds_i,
	decode_if.sink              d_i,
	output logic                valid_o,
	output logic                illegal_o,
	output decode_op_e          op_o,
	output logic [reg_w-1:0]    rt_o,
	output logic [reg_w-1:0]    ra_o,
	output logic                ra_or_zero_o,
	output logic [addr_w-1:0]   imm_o,
	output logic [addr_w-1:0]   pc_o
);

	logic                   en_q;  // Lines up with the decoder buses
	logic [addr_w-1:0]      pc_d1; // First pc stage, pc_o is the second
	logic                   sel_valid;
	decode_op_e             sel_op;
	logic [reg_w-1:0]       sel_rt;
	logic [reg_w-1:0]       sel_ra;
	logic                   sel_raz;
	logic [imm_field_w-1:0] sel_imm;
	imm_kind_e              sel_kind;
	logic                   unclaimed;

	function automatic logic [addr_w-1:0] extend_imm(
		input logic [imm_field_w-1:0] imm,
		input imm_kind_e               kind
	);
		case (kind)
			imm_sext, imm_sext_ds:
				return {{(addr_w-imm_field_w){imm[imm_field_w-1]}}, imm};
			imm_sext_hi:
				return {{(addr_w-2*imm_field_w){imm[imm_field_w-1]}}, imm,
					{imm_field_w{1'b0}}};
			default:
				return {{(addr_w-imm_field_w){1'b0}}, imm};
		endcase
	endfunction

	// Opcode sets are disjoint so at most one bus is valid
	always_comb begin
		sel_valid = 1'b1;
		if (ds_i.valid) begin
			sel_op   = ds_i.op;
			sel_rt   = ds_i.rt;
			sel_ra   = ds_i.ra;
			sel_raz  = ds_i.ra_or_zero;
			sel_imm  = ds_i.imm;
			sel_kind = ds_i.imm_kind;
		end else if (d_i.valid) begin
			sel_op   = d_i.op;
			sel_rt   = d_i.rt;
			sel_ra   = d_i.ra;
			sel_raz  = d_i.ra_or_zero;
			sel_imm  = d_i.imm;
			sel_kind = d_i.imm_kind;
		end else begin
			sel_valid = 1'b0;
			sel_op    = op_none; // Idle result is all zero
			sel_rt    = '0;
			sel_ra    = '0;
			sel_raz   = 1'b0;
			sel_imm   = '0;
			sel_kind  = imm_zext;
		end
	end

	assign unclaimed = en_q && !sel_valid;

	always_ff @(posedge clock_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			en_q         <= 1'b0;
			valid_o      <= 1'b0;
			illegal_o    <= 1'b0;
			op_o         <= op_none;
			rt_o         <= '0;
			ra_o         <= '0;
			ra_or_zero_o <= 1'b0;
			imm_o        <= '0;
			pc_o         <= '0;
		end else begin
			en_q         <= enable_i;
			valid_o      <= sel_valid;
			illegal_o    <= unclaimed;
			op_o         <= sel_op;
			rt_o         <= sel_rt;
			ra_o         <= sel_ra;
			ra_or_zero_o <= sel_raz;
			imm_o        <= extend_imm(sel_imm, sel_kind);
			pc_o         <= pc_d1; // Address of the word being reported
		end
	end

	always_ff @(posedge clock_i) begin
		pc_d1 <= pc_i;
	end

endmodule

//--- src/d_format_decoder.sv
`timescale 1ns/1ps

// D-format arithmetic, logical and word load/store words
module d_format_decoder import ppc_decode_pkg::*; (
	input  logic                 clock_i,
	input  logic                 arst_n_i,
	input  logic                 enable_i,
	input  logic [0:instr_w-1]   instr_i,
	decode_if.source             bus_o
);

	logic [opc_w-1:0] opcode;
	logic             hit;
	decode_op_e       op_next;
	imm_kind_e        kind_next;
	logic             raz_next;

	assign opcode = instr_i[0:opc_w-1];

	always_comb begin
		hit       = 1'b1;
		op_next   = op_none;
		kind_next = imm_sext;
		raz_next  = 1'b1;
		case (opcode)
			opc_addi: op_next = op_addi;
			opc_addis: begin
				op_next   = op_addis;
				kind_next = imm_sext_hi;
			end
			// Logical immediates are unsigned and RA is a real source
			opc_ori: begin
				op_next   = op_ori;
				kind_next = imm_zext;
				raz_next  = 1'b0;
			end
			opc_andi: begin
				op_next   = op_andi;
				kind_next = imm_zext;
				raz_next  = 1'b0;
			end
			opc_lwz: op_next = op_lwz;
			opc_stw: op_next = op_stw;
			default: hit = 1'b0; // Left to the other decoder or flagged illegal
		endcase
	end

	always_ff @(posedge clock_i or negedge arst_n_i) begin
		if (!arst_n_i)
			bus_o.valid <= 1'b0;
		else
			bus_o.valid <= enable_i && hit;
	end

	always_ff @(posedge clock_i) begin
		if (enable_i) begin
			bus_o.op         <= op_next;
			bus_o.rt         <= instr_i[6:10];  // RT, or RS for stores and logicals
			bus_o.ra         <= instr_i[11:15];
			bus_o.ra_or_zero <= raz_next;
			bus_o.imm        <= instr_i[16:31];
			bus_o.imm_kind   <= kind_next;
		end
	end

endmodule

//--- src/ds_format_decoder.sv
`timescale 1ns/1ps

// DS-format integer load/store words, primary opcodes 58 and 62
module ds_format_decoder import ppc_decode_pkg::*; (
	input  logic                 clock_i,
	input  logic                 arst_n_i,
	input  logic                 enable_i,
	input  logic [0:instr_w-1]   instr_i,
	decode_if.source             bus_o
);

	logic [opc_w-1:0] opcode;
	logic [1:0]       xo;
	logic             hit;
	decode_op_e       op_next;
	logic             raz_next;

	assign opcode = instr_i[0:opc_w-1];
	assign xo     = instr_i[30:31];

	always_comb begin
		hit      = 1'b0;
		op_next  = op_none;
		raz_next = 1'b1; // Only the update forms use RA as a real register
		if (opcode == opc_ds_load) begin
			hit = (xo != 2'd3); // XO 3 is not supported here
			case (xo)
				2'd0: op_next = op_ld;
				2'd1: begin
					op_next  = op_ldu;
					raz_next = 1'b0;
				end
				2'd2: op_next = op_lwa;
				default: op_next = op_none;
			endcase
		end else if (opcode == opc_ds_store) begin
			hit = (xo != 2'd3);
			case (xo)
				2'd0: op_next = op_std;
				2'd1: begin
					op_next  = op_stdu;
					raz_next = 1'b0;
				end
				2'd2: op_next = op_stq;
				default: op_next = op_none;
			endcase
		end
	end

	always_ff @(posedge clock_i or negedge arst_n_i) begin
		if (!arst_n_i)
			bus_o.valid <= 1'b0;
		else
			bus_o.valid <= enable_i && hit;
	end

	always_ff @(posedge clock_i) begin
		if (enable_i) begin
			bus_o.op         <= op_next;
			bus_o.rt         <= instr_i[6:10];
			bus_o.ra         <= instr_i[11:15];
			bus_o.ra_or_zero <= raz_next;
			bus_o.imm        <= {instr_i[16:29], 2'b00}; // Word-aligned displacement
			bus_o.imm_kind   <= imm_sext_ds;
		end
	end

endmodule

//--- src/decode_if.sv
`timescale 1ns/1ps

// Registered result of one format decoder on its way to the merge stage
interface decode_if import ppc_decode_pkg::*; ();

	logic                   valid;      // One-cycle strobe, no back-pressure
	decode_op_e             op;
	logic [reg_w-1:0]       rt;         // Instruction bits 6-10
	logic [reg_w-1:0]       ra;         // Instruction bits 11-15
	logic                   ra_or_zero; // RA of 0 reads as literal zero
	logic [imm_field_w-1:0] imm;
	imm_kind_e              imm_kind;

	modport source (
		output valid, op, rt, ra, ra_or_zero, imm, imm_kind
	);

	modport sink (
		input valid, op, rt, ra, ra_or_zero, imm, imm_kind
	);

endinterface

//--- src/ppc_decode_pkg.sv
package ppc_decode_pkg;

	localparam int instr_w     = 32; // Instruction word, bit 0 is the MSB
	localparam int addr_w      = 64; // Fetch address and extended immediate
	localparam int reg_w       = 5;  // GPR number
	localparam int imm_field_w = 16; // Immediate as carried between stages
	localparam int opc_w       = 6;  // Primary opcode in bits 0-5

	// DS-format primary opcodes, split further by the XO field in bits 30-31
	localparam logic [opc_w-1:0] opc_ds_load  = 6'd58; // ld, ldu, lwa
	localparam logic [opc_w-1:0] opc_ds_store = 6'd62; // std, stdu, stq

	// D-format primary opcodes
	localparam logic [opc_w-1:0] opc_addi  = 6'd14;
	localparam logic [opc_w-1:0] opc_addis = 6'd15;
	localparam logic [opc_w-1:0] opc_ori   = 6'd24;
	localparam logic [opc_w-1:0] opc_andi  = 6'd28; // andi. in the ISA, sets CR0
	localparam logic [opc_w-1:0] opc_lwz   = 6'd32;
	localparam logic [opc_w-1:0] opc_stw   = 6'd36;

	// One value per decoded instruction
	typedef enum logic [3:0] {
		op_none  = 4'd0,
		op_lwa,
		op_ld,
		op_ldu,
		op_std,
		op_stq,
		op_stdu,
		op_addi,
		op_addis,
		op_ori,
		op_andi,
		op_lwz,
		op_stw
	} decode_op_e;

	// How the merge stage widens the 16-bit immediate to 64 bits
	typedef enum logic [1:0] {
		imm_sext,    // Sign-extend the 16 bits
		imm_sext_ds, // DS displacement with 2'b00 appended, then sign-extend
		imm_sext_hi, // Shift left by 16, then sign-extend
		imm_zext     // Zero-extend
	} imm_kind_e;

endpackage
